/* design/dma_rd_consts.svh */
/* dma read engine constants
   beat geometry, field widths, destination codes, backup fifo sizing */

`ifndef DMA_RD_CONSTS_SVH
`define DMA_RD_CONSTS_SVH

// ----------------------------------------------------------
// data beat
// ----------------------------------------------------------
`define DMA_BEAT_BYTES 32
`define DMA_BEAT_W     256

// request and header fields
`define DMA_LEN_W      32
`define DMA_ADDR_W     64
`define DMA_HD_W       128

// ----------------------------------------------------------
// destination channels
// ----------------------------------------------------------
// wqe parser, network data download
`define DEST_WPDT      3'd1
// execution engine, read payload download
`define DEST_EEDT      3'd2

// backup request fifo
`define REQ_FIFO_DEPTH 64
// fill level where prog_full rises
`define REQ_FIFO_AFULL 60

`endif

/* design/dma_rd_pkg.sv */
/* dma read engine types
   segment request, dma read header and destination codes */

`include "dma_rd_consts.svh"

package dma_rd_pkg;

    // ----------------------------------------------------------
    // destination of a segment's data
    // ----------------------------------------------------------
    typedef enum logic [2:0] {
        dest_wp = `DEST_WPDT,
        dest_ee = `DEST_EEDT
    } dma_dest_e;

    // ----------------------------------------------------------
    // one memory segment of a message, 134 bits
    // ----------------------------------------------------------
    typedef struct packed {
        // byte length of the whole message
        logic [`DMA_LEN_W-1:0]  total_len;
        // reserved
        logic [2:0]             opcode;
        dma_dest_e              dest;
        // byte length of this segment
        logic [`DMA_LEN_W-1:0]  seg_len;
        // host physical address
        logic [`DMA_ADDR_W-1:0] addr;
    } dma_dt_req_t;

    // ----------------------------------------------------------
    // read header sent to the dma engine
    // ----------------------------------------------------------
    typedef struct packed {
        logic [`DMA_HD_W-`DMA_ADDR_W-`DMA_LEN_W-1:0] rsvd;
        logic [`DMA_ADDR_W-1:0]                      addr;
        logic [`DMA_LEN_W-1:0]                       byte_len;
    } dma_rd_head_t;

endpackage

/* design/dma_rd_req_fifo.sv */
/* backup request fifo
   first-word-fall-through buffer of issued requests awaiting data */

`timescale 1ns/10ps

`include "dma_rd_consts.svh"

module dma_rd_req_fifo #(
    parameter int depth = `REQ_FIFO_DEPTH,
    parameter int afull = `REQ_FIFO_AFULL
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    wr_en,
    input  dma_rd_pkg::dma_dt_req_t din,
    input  logic                    rd_en,
    output dma_rd_pkg::dma_dt_req_t dout,
    output logic                    empty,
    output logic                    prog_full
);
    import dma_rd_pkg::*;

    localparam int ptr_w = $clog2(depth);

    dma_dt_req_t      mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w:0]   count;
    logic             full;
    logic             do_wr;
    logic             do_rd;

    assign full      = count == (ptr_w+1)'(depth);
    assign empty     = count == '0;
    assign prog_full = count >= (ptr_w+1)'(afull);
    assign do_wr     = wr_en && !full;
    assign do_rd     = rd_en && !empty;

    // head is always visible
    assign dout = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + (ptr_w+1)'(do_wr) - (ptr_w+1)'(do_rd);
        end
    end

endmodule

/* design/dma_rd_issue.sv */
/* dma read issue path
   pops segment requests and sends one read header per request */

`timescale 1ns/10ps

module dma_rd_issue (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     req_empty,
    input  dma_rd_pkg::dma_dt_req_t  req_dout,
    output logic                     req_rd_en,
    input  logic                     dma_req_ready,
    input  logic                     bkup_prog_full,
    output logic                     dma_req_valid,
    output dma_rd_pkg::dma_rd_head_t dma_req_head
);
    import dma_rd_pkg::*;

    typedef enum logic {
        st_pop,
        st_issue
    } issue_state_e;

    issue_state_e state;
    issue_state_e state_nxt;
    dma_dt_req_t  hold_req;
    logic         can_go;
    logic         issue_go;

    // dma engine ready and room left in the backup fifo
    assign can_go    = dma_req_ready && !bkup_prog_full;
    assign req_rd_en = (state == st_pop) && !req_empty && can_go;
    assign issue_go  = (state == st_issue) && can_go;

    // ----------------------------------------------------------
    // fsm
    // ----------------------------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            st_pop: begin
                if (req_rd_en) begin
                    state_nxt = st_issue;
                end
            end
            st_issue: begin
                if (issue_go) begin
                    state_nxt = st_pop;
                end
            end
            default: state_nxt = st_pop;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_pop;
        end else begin
            state <= state_nxt;
        end
    end

    // popped request, held until its header goes out
    always_ff @(posedge clk) begin
        if (req_rd_en) begin
            hold_req <= req_dout;
        end
    end

    // ----------------------------------------------------------
    // header register, one cycle pulse
    // ----------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dma_req_valid <= 1'b0;
            dma_req_head  <= '0;
        end else begin
            dma_req_valid <= issue_go;
            dma_req_head  <= '0;
            if (issue_go) begin
                dma_req_head.addr     <= hold_req.addr;
                dma_req_head.byte_len <= hold_req.seg_len;
            end
        end
    end

endmodule

/* design/dma_rd_rsp_align.sv */
/* dma read response aligner
   packs segment bytes from response beats into dense 32-byte words
   and steers each word to its download channel */

`timescale 1ns/10ps

`include "dma_rd_consts.svh"

module dma_rd_rsp_align (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    bkup_empty,
    input  dma_rd_pkg::dma_dt_req_t bkup_req,
    output logic                    bkup_rd_en,
    input  logic                    rsp_tvalid,
    input  logic [`DMA_BEAT_W-1:0]  rsp_tdata,
    output logic                    rsp_tready,
    input  logic                    wp_prog_full,
    input  logic                    ee_prog_full,
    output logic                    wp_wr_en,
    output logic [`DMA_BEAT_W-1:0]  wp_data,
    output logic                    ee_wr_en,
    output logic [`DMA_BEAT_W-1:0]  ee_data
);
    import dma_rd_pkg::*;

    localparam int beat_bytes_c = `DMA_BEAT_BYTES;
    localparam int cnt_w        = $clog2(beat_bytes_c);

    typedef enum logic {
        st_idle,
        st_dl
    } align_state_e;

    align_state_e             state;
    align_state_e             state_nxt;
    dma_dest_e                cur_dest;
    logic [`DMA_LEN_W-1:0]    seg_left;
    logic [`DMA_LEN_W-1:0]    msg_left;
    logic [`DMA_BEAT_W-1:0]   carry_data;
    logic [cnt_w-1:0]         carry_cnt;
    logic                     word_vld;
    logic [`DMA_BEAT_W-1:0]   word_data;

    logic                     sel_full;
    logic                     last_seg;
    logic                     beat_take;
    logic                     final_beat;
    logic                     need_tail;
    logic                     zero_cyc;
    logic [cnt_w:0]           beat_cnt;
    logic [cnt_w:0]           sum_cnt;
    logic [`DMA_BEAT_W-1:0]   beat_mask;
    logic [2*`DMA_BEAT_W-1:0] merged;
    logic                     emit;
    logic [`DMA_BEAT_W-1:0]   emit_data;
    logic                     carry_upd;
    logic [`DMA_BEAT_W-1:0]   carry_data_nxt;
    logic [cnt_w-1:0]         carry_cnt_nxt;

    // fullness of the channel named by the fifo head, unknown code stalls
    always_comb begin
        sel_full = 1'b1;
        if (!bkup_empty) begin
            case (bkup_req.dest)
                dest_wp: sel_full = wp_prog_full;
                dest_ee: sel_full = ee_prog_full;
                default: sel_full = 1'b1;
            endcase
        end
    end

    // ----------------------------------------------------------
    // beat handshake and segment end
    // ----------------------------------------------------------
    assign last_seg   = msg_left == seg_left;
    assign rsp_tready = (state == st_dl) && (seg_left != '0) && !sel_full;
    assign beat_take  = rsp_tready && rsp_tvalid;
    assign final_beat = beat_take && (seg_left <= beat_bytes_c);
    // message tail spills past the word closed by the final beat
    assign need_tail  = last_seg && (sum_cnt > beat_bytes_c);
    assign zero_cyc   = (state == st_dl) && (seg_left == '0) && !sel_full;
    assign bkup_rd_en = (final_beat && !need_tail) || zero_cyc;

    // valid bytes of this beat, appended above the carried bytes
    assign beat_cnt  = (seg_left >= beat_bytes_c) ? (cnt_w+1)'(beat_bytes_c)
                                                  : seg_left[cnt_w:0];
    assign sum_cnt   = {1'b0, carry_cnt} + beat_cnt;
    assign beat_mask = ~({`DMA_BEAT_W{1'b1}} << {beat_cnt, 3'b000});
    assign merged    = ({{`DMA_BEAT_W{1'b0}}, rsp_tdata & beat_mask} << {carry_cnt, 3'b000})
                     | {{`DMA_BEAT_W{1'b0}}, carry_data};

    always_comb begin
        emit           = 1'b0;
        emit_data      = merged[`DMA_BEAT_W-1:0];
        carry_upd      = 1'b0;
        carry_data_nxt = '0;
        carry_cnt_nxt  = '0;
        if (beat_take) begin
            carry_upd = 1'b1;
            if (sum_cnt >= beat_bytes_c) begin
                // full word, overflow bytes carried on
                emit           = 1'b1;
                carry_data_nxt = merged[2*`DMA_BEAT_W-1:`DMA_BEAT_W];
                carry_cnt_nxt  = sum_cnt[cnt_w-1:0];
            end else if (final_beat && last_seg) begin
                emit = 1'b1;
            end else begin
                carry_data_nxt = merged[`DMA_BEAT_W-1:0];
                carry_cnt_nxt  = sum_cnt[cnt_w-1:0];
            end
        end else if (zero_cyc && last_seg && (carry_cnt != '0)) begin
            // late flush of the message's partial word
            emit      = 1'b1;
            emit_data = carry_data;
            carry_upd = 1'b1;
        end
    end

    // ----------------------------------------------------------
    // fsm and counters
    // ----------------------------------------------------------
    always_comb begin
        state_nxt = state;
        if (state == st_idle && !bkup_empty) begin
            state_nxt = st_dl;
        end else if (state == st_dl && bkup_rd_en) begin
            state_nxt = st_idle;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= st_idle;
            cur_dest <= dest_wp;
            seg_left <= '0;
            msg_left <= '0;
        end else begin
            state <= state_nxt;
            if (state == st_idle && !bkup_empty) begin
                cur_dest <= bkup_req.dest;
                seg_left <= bkup_req.seg_len;
                // first segment of a message
                if (msg_left == '0) begin
                    msg_left <= bkup_req.total_len;
                end
            end else if (beat_take) begin
                seg_left <= seg_left - beat_cnt;
                msg_left <= msg_left - beat_cnt;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            carry_data <= '0;
            carry_cnt  <= '0;
            word_vld   <= 1'b0;
        end else begin
            word_vld <= emit;
            if (carry_upd) begin
                carry_data <= carry_data_nxt;
                carry_cnt  <= carry_cnt_nxt;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (emit) begin
            word_data <= emit_data;
        end
    end

    // steer to the latched channel only
    assign wp_wr_en = word_vld && (cur_dest == dest_wp);
    assign wp_data  = (cur_dest == dest_wp) ? word_data : '0;
    assign ee_wr_en = word_vld && (cur_dest == dest_ee);
    assign ee_data  = (cur_dest == dest_ee) ? word_data : '0;

endmodule

/* design/dma_rd_top.sv */
/* dma read data engine
   issue path, backup request fifo and response aligner */

`timescale 1ns/10ps

`include "dma_rd_consts.svh"

module dma_rd_top (
    input  logic                     clk,
    input  logic                     rst,
    // upstream request fifo
    input  logic                     req_empty,
    input  dma_rd_pkg::dma_dt_req_t  req_dout,
    output logic                     req_rd_en,
    // dma engine request
    output logic                     dma_req_valid,
    output dma_rd_pkg::dma_rd_head_t dma_req_head,
    input  logic                     dma_req_ready,
    // dma engine response
    input  logic                     rsp_tvalid,
    input  logic [`DMA_BEAT_W-1:0]   rsp_tdata,
    output logic                     rsp_tready,
    // wqe parser download
    output logic                     wp_wr_en,
    output logic [`DMA_BEAT_W-1:0]   wp_data,
    input  logic                     wp_prog_full,
    // execution engine download
    output logic                     ee_wr_en,
    output logic [`DMA_BEAT_W-1:0]   ee_data,
    input  logic                     ee_prog_full
);
    import dma_rd_pkg::*;

    dma_dt_req_t bkup_req;
    logic        bkup_empty;
    logic        bkup_rd_en;
    logic        bkup_prog_full;

    dma_rd_issue issue_i (
        .clk            (clk),
        .rst            (rst),
        .req_empty      (req_empty),
        .req_dout       (req_dout),
        .req_rd_en      (req_rd_en),
        .dma_req_ready  (dma_req_ready),
        .bkup_prog_full (bkup_prog_full),
        .dma_req_valid  (dma_req_valid),
        .dma_req_head   (dma_req_head)
    );

    // every popped request is also kept for the response side
    dma_rd_req_fifo #(
        .depth (`REQ_FIFO_DEPTH),
        .afull (`REQ_FIFO_AFULL)
    ) bkup_fifo_i (
        .clk       (clk),
        .rst       (rst),
        .wr_en     (req_rd_en),
        .din       (req_dout),
        .rd_en     (bkup_rd_en),
        .dout      (bkup_req),
        .empty     (bkup_empty),
        .prog_full (bkup_prog_full)
    );

    dma_rd_rsp_align align_i (
        .clk          (clk),
        .rst          (rst),
        .bkup_empty   (bkup_empty),
        .bkup_req     (bkup_req),
        .bkup_rd_en   (bkup_rd_en),
        .rsp_tvalid   (rsp_tvalid),
        .rsp_tdata    (rsp_tdata),
        .rsp_tready   (rsp_tready),
        .wp_prog_full (wp_prog_full),
        .ee_prog_full (ee_prog_full),
        .wp_wr_en     (wp_wr_en),
        .wp_data      (wp_data),
        .ee_wr_en     (ee_wr_en),
        .ee_data      (ee_data)
    );

endmodule

/* dv/dma_rd_checker.sv */
/* dma read engine port checker
   concurrent assertions bound onto the top level */

`timescale 1ns/10ps

module dma_rd_checker (
    input logic       clk,
    input logic       rst,
    input logic       req_rd_en,
    input logic       dma_req_valid,
    input logic       rsp_tready,
    input logic       wp_wr_en,
    input logic       ee_wr_en,
    input logic       wp_prog_full,
    input logic       ee_prog_full,
    input logic [2:0] cur_dest
);

    logic sel_full;

    // fullness of the channel the aligner steers its words to
    assign sel_full = (cur_dest == 3'd1) ? wp_prog_full :
                      (cur_dest == 3'd2) ? ee_prog_full : 1'b1;

    // ----------------------------------------------------------
    // port rules
    // ----------------------------------------------------------
    wr_en_onehot: assert property (@(posedge clk) disable iff (rst)
        !(wp_wr_en && ee_wr_en))
        else $error("both download channels written in one cycle");

    tready_vs_full: assert property (@(posedge clk) disable iff (rst)
        rsp_tready |-> !sel_full)
        else $error("rsp_tready high while selected channel is full");

    valid_pulse: assert property (@(posedge clk) disable iff (rst)
        dma_req_valid |=> !dma_req_valid)
        else $error("dma_req_valid high for two cycles");

    reset_quiet: assert property (@(posedge clk)
        rst |-> !(req_rd_en || dma_req_valid || rsp_tready || wp_wr_en || ee_wr_en))
        else $error("control output high during reset");

endmodule

/* dv/dma_rd_tb.sv */
/* dma read engine testbench
   upstream fifo and dma models, per-channel scoreboard, directed tests */

`timescale 1ns/10ps

`include "dma_rd_consts.svh"

module dma_rd_tb;
    import dma_rd_pkg::*;

    logic                     clk = 1'b0;
    logic                     rst = 1'b1;
    logic                     req_empty = 1'b1;
    dma_dt_req_t              req_dout = '0;
    logic                     req_rd_en;
    logic                     dma_req_valid;
    dma_rd_head_t             dma_req_head;
    logic                     dma_req_ready = 1'b1;
    logic                     rsp_tvalid = 1'b0;
    logic [`DMA_BEAT_W-1:0]   rsp_tdata = '0;
    logic                     rsp_tready;
    logic                     wp_wr_en;
    logic [`DMA_BEAT_W-1:0]   wp_data;
    logic                     wp_prog_full = 1'b0;
    logic                     ee_wr_en;
    logic [`DMA_BEAT_W-1:0]   ee_data;
    logic                     ee_prog_full = 1'b0;

    dma_dt_req_t              up_q[$];
    dma_rd_head_t             hdr_q[$];
    dma_rd_head_t             hdr_log[$];
    dma_rd_head_t             exp_hdr[$];
    logic [7:0]               wp_exp[$];
    logic                     wp_care[$];
    logic [7:0]               ee_exp[$];
    logic                     ee_care[$];
    logic [`DMA_BEAT_W-1:0]   wp_got[$];
    logic [`DMA_BEAT_W-1:0]   ee_got[$];
    logic                     beat_taken = 1'b0;
    int                       beat_idx = 0;
    int                       seg_lens[4];
    int                       errors = 0;
    int                       checks = 0;
    int unsigned              rng = 43313;

    dma_rd_top dma_rd_top_i (.*);

    bind dma_rd_top dma_rd_checker checker_i (
        .clk           (clk),
        .rst           (rst),
        .req_rd_en     (req_rd_en),
        .dma_req_valid (dma_req_valid),
        .rsp_tready    (rsp_tready),
        .wp_wr_en      (wp_wr_en),
        .ee_wr_en      (ee_wr_en),
        .wp_prog_full  (wp_prog_full),
        .ee_prog_full  (ee_prog_full),
        .cur_dest      (align_i.cur_dest)
    );

    initial begin
        forever #10 clk = ~clk;
    end

    function automatic int unsigned lcg_next();
        rng = rng * 32'd1103515245 + 32'd12345;
        return rng >> 8;
    endfunction

    // ----------------------------------------------------------
    // monitors sample at the rising edge
    // ----------------------------------------------------------
    always @(posedge clk) begin
        if (req_rd_en && up_q.size() != 0) void'(up_q.pop_front());
        if (dma_req_valid) begin
            hdr_q.push_back(dma_req_head);
            hdr_log.push_back(dma_req_head);
        end
        if (rsp_tvalid && rsp_tready) beat_taken = 1'b1;
        if (wp_wr_en) wp_got.push_back(wp_data);
        if (ee_wr_en) ee_got.push_back(ee_data);
    end

    // upstream fifo and dma response driven on the falling edge
    always @(negedge clk) begin
        req_empty = (up_q.size() == 0);
        req_dout  = req_empty ? '0 : up_q[0];
        if (beat_taken) begin
            beat_taken = 1'b0;
            beat_idx++;
            if (beat_idx * 32 >= int'(hdr_q[0].byte_len)) begin
                void'(hdr_q.pop_front());
                beat_idx = 0;
            end
        end
        rsp_tvalid = (hdr_q.size() != 0);
        rsp_tdata  = '0;
        if (rsp_tvalid) begin
            for (int i = 0; i < 32; i++) begin
                rsp_tdata[8*i +: 8] = 8'(hdr_q[0].addr + 64'(beat_idx * 32 + i));
            end
        end
    end

    // queue one message from seg_lens and pack its expected bytes low lane first
    task automatic queue_msg(input logic [2:0] dest, input int nseg);
        int          total;
        dma_dt_req_t r;
        logic [63:0] a;
        total = 0;
        for (int i = 0; i < nseg; i++) total += seg_lens[i];
        for (int i = 0; i < nseg; i++) begin
            a = {32'h0000_0001, lcg_next()};
            r = '0;
            r.total_len = 32'(total);
            r.dest      = dma_dest_e'(dest);
            r.seg_len   = 32'(seg_lens[i]);
            r.addr      = a;
            up_q.push_back(r);
            exp_hdr.push_back({32'h0, a, 32'(seg_lens[i])});
            for (int j = 0; j < seg_lens[i]; j++) begin
                if (dest == `DEST_WPDT) begin
                    wp_exp.push_back(8'(a + 64'(j)));
                    wp_care.push_back(1'b1);
                end else begin
                    ee_exp.push_back(8'(a + 64'(j)));
                    ee_care.push_back(1'b1);
                end
            end
        end
        // bytes past the message end are not checked
        while (wp_exp.size() % 32 != 0) begin
            wp_exp.push_back(8'h00);
            wp_care.push_back(1'b0);
        end
        while (ee_exp.size() % 32 != 0) begin
            ee_exp.push_back(8'h00);
            ee_care.push_back(1'b0);
        end
    endtask

    task automatic finish_run();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    endtask

    task automatic wait_done(input string name);
        int n;
        n = 0;
        while (!(up_q.size() == 0 && hdr_q.size() == 0
                 && wp_got.size() * 32 >= wp_exp.size()
                 && ee_got.size() * 32 >= ee_exp.size())) begin
            @(posedge clk);
            n++;
            if (n > 5000) begin
                errors++;
                $display("%s: timed out waiting for data to drain", name);
                finish_run();
            end
        end
        repeat (4) @(posedge clk);
    endtask

    // ----------------------------------------------------------
    // compare headers and words and clear the scoreboard
    // ----------------------------------------------------------
    task automatic check_results(input string name);
        logic [`DMA_BEAT_W-1:0] exp_w;
        logic [`DMA_BEAT_W-1:0] got_w;
        int                     n;
        int                     exp_n;
        checks++;
        assert (hdr_log.size() == exp_hdr.size()) else begin
            errors++;
            $display("[ERROR] %s header count expected %0d actual %0d", name,
                     exp_hdr.size(), hdr_log.size());
        end
        for (int i = 0; i < hdr_log.size() && i < exp_hdr.size(); i++) begin
            checks++;
            assert (hdr_log[i] == exp_hdr[i]) else begin
                errors++;
                $display("[ERROR] %s header %0d expected %h actual %h", name, i,
                         exp_hdr[i], hdr_log[i]);
            end
        end
        for (int ch = 0; ch < 2; ch++) begin
            n     = (ch == 0) ? wp_got.size() : ee_got.size();
            exp_n = ((ch == 0) ? wp_exp.size() : ee_exp.size()) / 32;
            checks++;
            assert (n == exp_n) else begin
                errors++;
                $display("[ERROR] %s ch %0d word count expected %0d actual %0d", name, ch,
                         exp_n, n);
            end
            for (int w = 0; w < n && w < exp_n; w++) begin
                got_w = (ch == 0) ? wp_got[w] : ee_got[w];
                exp_w = got_w;
                for (int b = 0; b < 32; b++) begin
                    if ((ch == 0) ? wp_care[w*32+b] : ee_care[w*32+b]) begin
                        exp_w[8*b +: 8] = (ch == 0) ? wp_exp[w*32+b] : ee_exp[w*32+b];
                    end
                end
                checks++;
                assert (got_w == exp_w) else begin
                    errors++;
                    $display("[ERROR] %s ch %0d word %0d expected %h actual %h", name, ch, w,
                             exp_w, got_w);
                end
            end
        end
        hdr_log.delete();
        exp_hdr.delete();
        wp_exp.delete();
        wp_care.delete();
        ee_exp.delete();
        ee_care.delete();
        wp_got.delete();
        ee_got.delete();
    endtask

    // ----------------------------------------------------------
    // directed tests
    // ----------------------------------------------------------
    task automatic test_headers();
        @(negedge clk);
        seg_lens[0] = 64;
        queue_msg(`DEST_WPDT, 1);
        wait_done("headers");
        check_results("headers");
    endtask

    task automatic test_packing();
        @(negedge clk);
        seg_lens[0] = 20;
        seg_lens[1] = 30;
        seg_lens[2] = 15;
        queue_msg(`DEST_EEDT, 3);
        wait_done("packing");
        check_results("packing");
    endtask

    task automatic test_order();
        @(negedge clk);
        for (int m = 0; m < 4; m++) begin
            seg_lens[0] = 10 + 23 * m;
            queue_msg((m % 2 == 0) ? `DEST_WPDT : `DEST_EEDT, 1);
        end
        wait_done("order");
        check_results("order");
    endtask

    task automatic test_backpressure();
        @(negedge clk);
        ee_prog_full = 1'b1;
        seg_lens[0] = 70;
        queue_msg(`DEST_EEDT, 1);
        repeat (40) begin
            @(posedge clk);
            checks++;
            assert (!ee_wr_en && !rsp_tready) else begin
                errors++;
                $display("backpressure: output moved while ee channel was full");
            end
        end
        @(negedge clk);
        ee_prog_full = 1'b0;
        wait_done("backpressure");
        check_results("backpressure");
        @(negedge clk);
        dma_req_ready = 1'b0;
        seg_lens[0] = 40;
        queue_msg(`DEST_WPDT, 1);
        repeat (30) @(posedge clk);
        checks++;
        assert (hdr_log.size() == 0) else begin
            errors++;
            $display("backpressure: header sent while dma engine was not ready");
        end
        @(negedge clk);
        dma_req_ready = 1'b1;
        wait_done("ready_hold");
        check_results("ready_hold");
    endtask

    task automatic test_random();
        int nseg;
        @(negedge clk);
        for (int m = 0; m < 12; m++) begin
            nseg = 1 + int'(lcg_next() % 4);
            for (int i = 0; i < nseg; i++) seg_lens[i] = 1 + int'(lcg_next() % 100);
            queue_msg((m % 2 == 0) ? `DEST_WPDT : `DEST_EEDT, nseg);
        end
        wait_done("random");
        check_results("random");
    endtask

    initial begin
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        test_headers();
        test_packing();
        test_order();
        test_backpressure();
        test_random();
        finish_run();
    end

endmodule

/* build.f */
+incdir+design
design/dma_rd_pkg.sv
design/dma_rd_req_fifo.sv
design/dma_rd_issue.sv
design/dma_rd_rsp_align.sv
design/dma_rd_top.sv
dv/dma_rd_checker.sv
dv/dma_rd_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the dma read engine testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module dma_rd_tb \
    --Mdir obj_dir -o dma_rd_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/dma_rd_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Done: no errors"; then
    exit 0
fi
echo "simulation reported failure"
exit 1
